/* design/state_cache_pkg.sv */
package state_cache_pkg;

    // ------------------------------------------------------------------
    // Default sizes
    // ------------------------------------------------------------------
    localparam int KEY_W_DEF   = 16;
    localparam int ID_W_DEF    = 5;
    localparam int NUM_IDS_DEF = 32;
    localparam int INDEX_W_DEF = 6;
    localparam int CNT_W_DEF   = 32;

    // Request to ack, in cycles
    localparam int LOOKUP_LATENCY = 2;

    typedef enum logic [1:0] {
        OUTCOME_HIT,
        OUTCOME_FORWARD,
        OUTCOME_INSERT,
        OUTCOME_NOT_TRACKED
    } lookup_outcome_e;

    typedef enum logic {
        ALLOC_FILL,
        ALLOC_RUN
    } alloc_state_e;

    // XOR fold of the key in index_w chunks, top chunk zero padded
    function automatic logic [31:0] key_to_index(input logic [63:0] key,
                                                 input int key_w,
                                                 input int index_w);
        logic [31:0] idx;
        idx = '0;
        for (int b = 0; b < 64; b++) begin
            if (b < key_w) begin
                idx[b % index_w] = idx[b % index_w] ^ key[b];
            end
        end
        return idx;
    endfunction

endpackage

/* design/key_table.sv */
`timescale 1ns/100ps
module key_table #(
    parameter int KEY_W   = state_cache_pkg::KEY_W_DEF,
    parameter int ID_W    = state_cache_pkg::ID_W_DEF,
    parameter int INDEX_W = state_cache_pkg::INDEX_W_DEF
) (
    input  logic               clk,
    input  logic               htable_srst,
    input  logic               i_rd_req,
    input  logic [KEY_W-1:0]   i_rd_key,
    input  logic               i_wr_req,
    input  logic [INDEX_W-1:0] i_wr_index,
    input  logic [KEY_W-1:0]   i_wr_key,
    input  logic [ID_W-1:0]    i_wr_id,
    input  logic               i_clr_req,
    input  logic [INDEX_W-1:0] i_clr_index,
    output logic               o_rd_entry_valid,
    output logic [KEY_W-1:0]   o_rd_entry_key,
    output logic [ID_W-1:0]    o_rd_entry_id
);
    import state_cache_pkg::*;

    localparam int NUM_SLOTS = 2**INDEX_W;

    logic [KEY_W-1:0]     key_mem [NUM_SLOTS];
    logic [ID_W-1:0]      id_mem  [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] slot_valid;
    logic [INDEX_W-1:0]   rd_index;
    logic                 wr_hits_rd;
    logic                 clr_hits_rd;

    assign rd_index    = INDEX_W'(key_to_index(64'(i_rd_key), KEY_W, INDEX_W));
    assign wr_hits_rd  = i_wr_req && (i_wr_index == rd_index);
    assign clr_hits_rd = i_clr_req && (i_clr_index == rd_index);

    // ------------------------------------------------------------------
    // Entry store
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_wr_req) begin
            key_mem[i_wr_index] <= i_wr_key;
            id_mem[i_wr_index]  <= i_wr_id;
        end
    end

    // Insert wins over a clear of the same slot
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            slot_valid <= '0;
        end else begin
            if (i_clr_req) begin
                slot_valid[i_clr_index] <= 1'b0;
            end
            if (i_wr_req) begin
                slot_valid[i_wr_index] <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Registered read, write-first on the same slot
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            o_rd_entry_valid <= 1'b0;
        end else if (i_rd_req) begin
            if (wr_hits_rd) begin
                o_rd_entry_valid <= 1'b1;
            end else begin
                o_rd_entry_valid <= slot_valid[rd_index] && !clr_hits_rd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_req) begin
            if (wr_hits_rd) begin
                o_rd_entry_key <= i_wr_key;
                o_rd_entry_id  <= i_wr_id;
            end else begin
                o_rd_entry_key <= key_mem[rd_index];
                o_rd_entry_id  <= id_mem[rd_index];
            end
        end
    end

endmodule

/* design/lookup_ctxt_pipe.sv */
`timescale 1ns/100ps
module lookup_ctxt_pipe #(
    parameter int KEY_W = state_cache_pkg::KEY_W_DEF
) (
    input  logic             clk,
    input  logic             htable_srst,
    input  logic             i_req,
    input  logic [KEY_W-1:0] i_key,
    output logic             o_valid,
    output logic [KEY_W-1:0] o_key,
    output logic             o_back_to_back
);
    import state_cache_pkg::*;

    logic [LOOKUP_LATENCY-1:0] valid_sr;
    logic [LOOKUP_LATENCY-1:0] b2b_sr;
    logic [KEY_W-1:0]          key_sr [LOOKUP_LATENCY];
    logic                      last_key_valid;
    logic [KEY_W-1:0]          last_key;

    // Last accepted key
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            last_key_valid <= 1'b0;
        end else if (i_req) begin
            last_key_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req) begin
            last_key <= i_key;
        end
    end

    // Context shift register, in step with the table read
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[LOOKUP_LATENCY-2:0], i_req};
        end
    end

    always_ff @(posedge clk) begin
        b2b_sr    <= {b2b_sr[LOOKUP_LATENCY-2:0], last_key_valid && (i_key == last_key)};
        key_sr[0] <= i_key;
        for (int s = 1; s < LOOKUP_LATENCY; s++) begin
            key_sr[s] <= key_sr[s-1];
        end
    end

    assign o_valid        = valid_sr[LOOKUP_LATENCY-1];
    assign o_key          = key_sr[LOOKUP_LATENCY-1];
    assign o_back_to_back = b2b_sr[LOOKUP_LATENCY-1];

endmodule

/* design/id_allocator.sv */
`timescale 1ns/100ps
module id_allocator #(
    parameter int ID_W    = state_cache_pkg::ID_W_DEF,
    parameter int NUM_IDS = state_cache_pkg::NUM_IDS_DEF,
    parameter int INDEX_W = state_cache_pkg::INDEX_W_DEF
) (
    input  logic               clk,
    input  logic               htable_srst,
    input  logic               i_alloc_req,
    input  logic [INDEX_W-1:0] i_alloc_index,
    input  logic               i_delete_req,
    input  logic [ID_W-1:0]    i_delete_id,
    output logic               o_free_valid,
    output logic [ID_W-1:0]    o_free_id,
    output logic               o_clr_req,
    output logic [INDEX_W-1:0] o_clr_index,
    output logic               o_init_done,
    output logic [ID_W:0]      o_fill
);
    import state_cache_pkg::*;

    alloc_state_e       state;
    logic [ID_W-1:0]    free_mem [NUM_IDS];
    logic [INDEX_W-1:0] slot_map [NUM_IDS];
    logic [ID_W-1:0]    head;
    logic [ID_W-1:0]    tail;
    logic [ID_W:0]      free_cnt;
    logic [ID_W-1:0]    fill_id;
    logic [NUM_IDS-1:0] in_use;
    logic               pop;
    logic               push;
    logic [ID_W-1:0]    push_id;
    logic               del_accept;
    logic               del_q;
    logic [ID_W-1:0]    del_id_q;

    function automatic logic [ID_W-1:0] next_ptr(input logic [ID_W-1:0] ptr);
        return (ptr == ID_W'(NUM_IDS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_init_done  = (state == ALLOC_RUN);
    assign o_free_valid = o_init_done && (free_cnt != '0);
    assign o_free_id    = free_mem[head];
    assign pop          = i_alloc_req && o_free_valid;
    assign del_accept   = i_delete_req && in_use[i_delete_id];
    assign push         = (state == ALLOC_FILL) || del_q;
    assign push_id      = (state == ALLOC_FILL) ? fill_id : del_id_q;
    assign o_clr_req    = del_q;
    assign o_clr_index  = slot_map[del_id_q];

    // ------------------------------------------------------------------
    // Post-reset fill, then free-list pointers and counts
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state    <= ALLOC_FILL;
            fill_id  <= '0;
            head     <= '0;
            tail     <= '0;
            free_cnt <= '0;
            o_fill   <= '0;
            del_q    <= 1'b0;
        end else begin
            if (state == ALLOC_FILL) begin
                fill_id <= fill_id + 1'b1;
                if (fill_id == ID_W'(NUM_IDS - 1)) begin
                    state <= ALLOC_RUN;
                end
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (push && !pop) begin
                free_cnt <= free_cnt + 1'b1;
            end else if (pop && !push) begin
                free_cnt <= free_cnt - 1'b1;
            end
            if (pop && !del_q) begin
                o_fill <= o_fill + 1'b1;
            end else if (del_q && !pop) begin
                o_fill <= o_fill - 1'b1;
            end
            del_q <= del_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            in_use <= '0;
        end else begin
            if (del_accept) begin
                in_use[i_delete_id] <= 1'b0;
            end
            if (pop) begin
                in_use[o_free_id] <= 1'b1;
            end
        end
    end

    // Free-list storage and ID to slot map
    always_ff @(posedge clk) begin
        if (push) begin
            free_mem[tail] <= push_id;
        end
        if (pop) begin
            slot_map[o_free_id] <= i_alloc_index;
        end
        del_id_q <= i_delete_id;
    end

endmodule

/* design/lookup_resolver.sv */
`timescale 1ns/100ps
module lookup_resolver #(
    parameter int KEY_W   = state_cache_pkg::KEY_W_DEF,
    parameter int ID_W    = state_cache_pkg::ID_W_DEF,
    parameter int INDEX_W = state_cache_pkg::INDEX_W_DEF,
    parameter int CNT_W   = state_cache_pkg::CNT_W_DEF
) (
    input  logic               clk,
    input  logic               htable_srst,
    input  logic               i_ctxt_valid,
    input  logic [KEY_W-1:0]   i_ctxt_key,
    input  logic               i_back_to_back,
    input  logic               i_entry_valid,
    input  logic [KEY_W-1:0]   i_entry_key,
    input  logic [ID_W-1:0]    i_entry_id,
    input  logic               i_free_valid,
    input  logic [ID_W-1:0]    i_free_id,
    input  logic               i_cnt_clear,
    output logic               o_lookup_ack,
    output logic               o_lookup_valid,
    output logic               o_lookup_new,
    output logic [ID_W-1:0]    o_lookup_id,
    output logic               o_wr_req,
    output logic [INDEX_W-1:0] o_wr_index,
    output logic [KEY_W-1:0]   o_wr_key,
    output logic [ID_W-1:0]    o_wr_id,
    output logic               o_alloc_req,
    output logic [INDEX_W-1:0] o_alloc_index,
    output logic [CNT_W-1:0]   o_cnt_req,
    output logic [CNT_W-1:0]   o_cnt_tracked_existing,
    output logic [CNT_W-1:0]   o_cnt_tracked_new,
    output logic [CNT_W-1:0]   o_cnt_not_tracked
);
    import state_cache_pkg::*;

    logic               entry_valid_q;
    logic [KEY_W-1:0]   entry_key_q;
    logic [ID_W-1:0]    entry_id_q;
    logic               wr_q;
    logic [INDEX_W-1:0] wr_index_q;
    logic [KEY_W-1:0]   wr_key_q;
    logic [ID_W-1:0]    wr_id_q;
    logic [INDEX_W-1:0] ctxt_index;
    logic               slot_valid;
    logic [KEY_W-1:0]   slot_key;
    logic [ID_W-1:0]    slot_id;
    lookup_outcome_e    outcome;
    logic               last_valid;
    logic [ID_W-1:0]    last_id;
    logic               ack_q;
    lookup_outcome_e    outcome_q;

    assign ctxt_index = INDEX_W'(key_to_index(64'(i_ctxt_key), KEY_W, INDEX_W));

    // Table data and last insert, both registered
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            entry_valid_q <= 1'b0;
            wr_q          <= 1'b0;
        end else begin
            entry_valid_q <= i_entry_valid;
            wr_q          <= o_wr_req;
        end
    end

    always_ff @(posedge clk) begin
        entry_key_q <= i_entry_key;
        entry_id_q  <= i_entry_id;
        wr_index_q  <= o_wr_index;
        wr_key_q    <= o_wr_key;
        wr_id_q     <= o_wr_id;
    end

    // An insert one cycle earlier landed after this lookup's table read
    always_comb begin
        if (wr_q && (wr_index_q == ctxt_index)) begin
            slot_valid = 1'b1;
            slot_key   = wr_key_q;
            slot_id    = wr_id_q;
        end else begin
            slot_valid = entry_valid_q;
            slot_key   = entry_key_q;
            slot_id    = entry_id_q;
        end
    end

    // ------------------------------------------------------------------
    // Outcome
    // ------------------------------------------------------------------
    always_comb begin
        if (slot_valid && (slot_key == i_ctxt_key)) begin
            outcome = OUTCOME_HIT;
        end else if (i_back_to_back && last_valid) begin
            outcome = OUTCOME_FORWARD;
        end else if (!slot_valid && i_free_valid) begin
            outcome = OUTCOME_INSERT;
        end else begin
            outcome = OUTCOME_NOT_TRACKED;
        end
    end

    always_comb begin
        case (outcome)
            OUTCOME_HIT:     o_lookup_id = slot_id;
            OUTCOME_FORWARD: o_lookup_id = last_id;
            OUTCOME_INSERT:  o_lookup_id = i_free_id;
            default:         o_lookup_id = '0;
        endcase
    end

    assign o_lookup_ack   = i_ctxt_valid;
    assign o_lookup_valid = i_ctxt_valid && (outcome != OUTCOME_NOT_TRACKED);
    assign o_lookup_new   = i_ctxt_valid && (outcome == OUTCOME_INSERT);

    // Auto-insert of the missing key
    assign o_wr_req      = o_lookup_new;
    assign o_wr_index    = ctxt_index;
    assign o_wr_key      = i_ctxt_key;
    assign o_wr_id       = i_free_id;
    assign o_alloc_req   = o_lookup_new;
    assign o_alloc_index = ctxt_index;

    // Previous result, kept for one cycle only
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            last_valid <= 1'b0;
            ack_q      <= 1'b0;
            outcome_q  <= OUTCOME_HIT;
        end else begin
            last_valid <= o_lookup_valid;
            ack_q      <= o_lookup_ack;
            outcome_q  <= outcome;
        end
    end

    always_ff @(posedge clk) begin
        if (o_lookup_ack) begin
            last_id <= o_lookup_id;
        end
    end

    // ------------------------------------------------------------------
    // Counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst || i_cnt_clear) begin
            o_cnt_req              <= '0;
            o_cnt_tracked_existing <= '0;
            o_cnt_tracked_new      <= '0;
            o_cnt_not_tracked      <= '0;
        end else if (ack_q) begin
            o_cnt_req <= o_cnt_req + 1'b1;
            case (outcome_q)
                OUTCOME_INSERT:      o_cnt_tracked_new <= o_cnt_tracked_new + 1'b1;
                OUTCOME_NOT_TRACKED: o_cnt_not_tracked <= o_cnt_not_tracked + 1'b1;
                default:             o_cnt_tracked_existing <= o_cnt_tracked_existing + 1'b1;
            endcase
        end
    end

endmodule

/* design/state_cache_top.sv */
`timescale 1ns/100ps
module state_cache_top #(
    parameter int KEY_W   = state_cache_pkg::KEY_W_DEF,
    parameter int ID_W    = state_cache_pkg::ID_W_DEF,
    parameter int NUM_IDS = state_cache_pkg::NUM_IDS_DEF,
    parameter int INDEX_W = state_cache_pkg::INDEX_W_DEF,
    parameter int CNT_W   = state_cache_pkg::CNT_W_DEF
) (
    input  logic             clk,
    input  logic             htable_srst,
    input  logic             i_lookup_req,
    input  logic [KEY_W-1:0] i_lookup_key,
    input  logic             i_delete_req,
    input  logic [ID_W-1:0]  i_delete_id,
    input  logic             i_cnt_clear,
    output logic             o_init_done,
    output logic             o_lookup_ack,
    output logic             o_lookup_valid,
    output logic             o_lookup_new,
    output logic [ID_W-1:0]  o_lookup_id,
    output logic [ID_W:0]    o_fill,
    output logic [CNT_W-1:0] o_cnt_req,
    output logic [CNT_W-1:0] o_cnt_tracked_existing,
    output logic [CNT_W-1:0] o_cnt_tracked_new,
    output logic [CNT_W-1:0] o_cnt_not_tracked
);

    logic               lookup_req;
    logic               delete_req;
    logic               entry_valid;
    logic [KEY_W-1:0]   entry_key;
    logic [ID_W-1:0]    entry_id;
    logic               ctxt_valid;
    logic [KEY_W-1:0]   ctxt_key;
    logic               back_to_back;
    logic               wr_req;
    logic [INDEX_W-1:0] wr_index;
    logic [KEY_W-1:0]   wr_key;
    logic [ID_W-1:0]    wr_id;
    logic               alloc_req;
    logic [INDEX_W-1:0] alloc_index;
    logic               free_valid;
    logic [ID_W-1:0]    free_id;
    logic               clr_req;
    logic [INDEX_W-1:0] clr_index;

    // Nothing is accepted until the free list is filled
    assign lookup_req = i_lookup_req && o_init_done;
    assign delete_req = i_delete_req && o_init_done;

    key_table #(
        .KEY_W       (KEY_W),
        .ID_W        (ID_W),
        .INDEX_W     (INDEX_W)
    ) u_key_table (
        .clk              (clk),
        .htable_srst      (htable_srst),
        .i_rd_req         (lookup_req),
        .i_rd_key         (i_lookup_key),
        .i_wr_req         (wr_req),
        .i_wr_index       (wr_index),
        .i_wr_key         (wr_key),
        .i_wr_id          (wr_id),
        .i_clr_req        (clr_req),
        .i_clr_index      (clr_index),
        .o_rd_entry_valid (entry_valid),
        .o_rd_entry_key   (entry_key),
        .o_rd_entry_id    (entry_id)
    );

    lookup_ctxt_pipe #(
        .KEY_W (KEY_W)
    ) u_lookup_ctxt_pipe (
        .clk            (clk),
        .htable_srst    (htable_srst),
        .i_req          (lookup_req),
        .i_key          (i_lookup_key),
        .o_valid        (ctxt_valid),
        .o_key          (ctxt_key),
        .o_back_to_back (back_to_back)
    );

    id_allocator #(
        .ID_W    (ID_W),
        .NUM_IDS (NUM_IDS),
        .INDEX_W (INDEX_W)
    ) u_id_allocator (
        .clk           (clk),
        .htable_srst   (htable_srst),
        .i_alloc_req   (alloc_req),
        .i_alloc_index (alloc_index),
        .i_delete_req  (delete_req),
        .i_delete_id   (i_delete_id),
        .o_free_valid  (free_valid),
        .o_free_id     (free_id),
        .o_clr_req     (clr_req),
        .o_clr_index   (clr_index),
        .o_init_done   (o_init_done),
        .o_fill        (o_fill)
    );

    lookup_resolver #(
        .KEY_W   (KEY_W),
        .ID_W    (ID_W),
        .INDEX_W (INDEX_W),
        .CNT_W   (CNT_W)
    ) u_lookup_resolver (
        .clk                    (clk),
        .htable_srst            (htable_srst),
        .i_ctxt_valid           (ctxt_valid),
        .i_ctxt_key             (ctxt_key),
        .i_back_to_back         (back_to_back),
        .i_entry_valid          (entry_valid),
        .i_entry_key            (entry_key),
        .i_entry_id             (entry_id),
        .i_free_valid           (free_valid),
        .i_free_id              (free_id),
        .i_cnt_clear            (i_cnt_clear),
        .o_lookup_ack           (o_lookup_ack),
        .o_lookup_valid         (o_lookup_valid),
        .o_lookup_new           (o_lookup_new),
        .o_lookup_id            (o_lookup_id),
        .o_wr_req               (wr_req),
        .o_wr_index             (wr_index),
        .o_wr_key               (wr_key),
        .o_wr_id                (wr_id),
        .o_alloc_req            (alloc_req),
        .o_alloc_index          (alloc_index),
        .o_cnt_req              (o_cnt_req),
        .o_cnt_tracked_existing (o_cnt_tracked_existing),
        .o_cnt_tracked_new      (o_cnt_tracked_new),
        .o_cnt_not_tracked      (o_cnt_not_tracked)
    );

endmodule

/* sim/tb_state_cache_assert.sv */
`timescale 1ns/100ps
module state_cache_assert (
    input logic clk,
    input logic htable_srst,
    input logic i_lookup_req,
    input logic i_init_done,
    input logic i_lookup_ack,
    input logic i_lookup_valid,
    input logic i_lookup_new
);
    import state_cache_pkg::*;

    logic accepted;

    // Requests only count once the free list is filled
    assign accepted = i_lookup_req && i_init_done;

    // ------------------------------------------------------------------
    // Lookup protocol
    // ------------------------------------------------------------------
    ack_latency: assert property (@(posedge clk) disable iff (htable_srst)
        i_lookup_ack == $past(accepted, LOOKUP_LATENCY))
        else $error("lookup ack not %0d cycles after its request", LOOKUP_LATENCY);

    new_implies_valid: assert property (@(posedge clk) disable iff (htable_srst)
        i_lookup_new |-> i_lookup_valid)
        else $error("new result flagged without a valid ID");

    ack_after_init: assert property (@(posedge clk) disable iff (htable_srst)
        i_lookup_ack |-> i_init_done)
        else $error("lookup ack before init done");

endmodule

/* sim/tb_state_cache.sv */
`timescale 1ns/100ps
module tb_state_cache;
    import state_cache_pkg::*;

    localparam int KEY_W   = KEY_W_DEF;
    localparam int ID_W    = ID_W_DEF;
    localparam int NUM_IDS = NUM_IDS_DEF;
    localparam int CNT_W   = CNT_W_DEF;
    localparam int INDEX_W = INDEX_W_DEF;
    localparam int SLOTS   = 2**INDEX_W;
    localparam int TIMEOUT = 100;

    typedef struct packed {
        logic valid;
        logic is_new;
        int   id;
        int   cycle;
    } result_t;

    logic             clk = 1'b0;
    logic             htable_srst;
    logic             i_lookup_req;
    logic [KEY_W-1:0] i_lookup_key;
    logic             i_delete_req;
    logic [ID_W-1:0]  i_delete_id;
    logic             i_cnt_clear;
    logic             o_init_done;
    logic             o_lookup_ack;
    logic             o_lookup_valid;
    logic             o_lookup_new;
    logic [ID_W-1:0]  o_lookup_id;
    logic [ID_W:0]    o_fill;
    logic [CNT_W-1:0] o_cnt_req;
    logic [CNT_W-1:0] o_cnt_tracked_existing;
    logic [CNT_W-1:0] o_cnt_tracked_new;
    logic [CNT_W-1:0] o_cnt_not_tracked;

    // Reference model state
    bit      m_valid [SLOTS];
    int      m_key [SLOTS];
    int      m_id [SLOTS];
    bit      m_in_use [NUM_IDS];
    int      m_slot [NUM_IDS];
    int      free_q[$];
    result_t exp_q[$];
    int      m_fill = 0;
    int      t_req = 0;
    int      t_exist = 0;
    int      t_new = 0;
    int      t_nt = 0;
    bit      prev_req = 1'b0;
    bit      prev_valid = 1'b0;
    int      prev_key = 0;
    int      prev_id = 0;
    int      seed = 32'hf792;
    int      cycle_cnt = 0;
    int      checks = 0;
    int      errors = 0;
    int      test_num = 0;
    int      test_base = 0;

    state_cache_top u_dut (.*);

    bind state_cache_top state_cache_assert u_assert (
        .clk            (clk),
        .htable_srst    (htable_srst),
        .i_lookup_req   (i_lookup_req),
        .i_init_done    (o_init_done),
        .i_lookup_ack   (o_lookup_ack),
        .i_lookup_valid (o_lookup_valid),
        .i_lookup_new   (o_lookup_new)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------------------------------------------
    // Model and checks
    // ------------------------------------------------------------------
    // XOR of the key's INDEX_W-bit chunks
    function automatic int slot_of(input int key);
        int idx;
        idx = 0;
        for (int c = 0; c < KEY_W; c += INDEX_W) begin
            idx = idx ^ ((key >> c) & (SLOTS - 1));
        end
        return idx;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Error at %0t ns: timed out waiting for %s", $time, what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("Test %0d %s: %0d errors", test_num, name, errors - test_base);
        test_base = errors;
    endtask

    task automatic model_lookup(input int key);
        result_t r;
        int s;
        s = slot_of(key);
        r.cycle  = cycle_cnt;
        r.valid  = 1'b1;
        r.is_new = 1'b0;
        r.id     = 0;
        if (m_valid[s] && m_key[s] == key) begin
            r.id = m_id[s];
            t_exist++;
        end else if (prev_req && prev_valid && prev_key == key) begin
            r.id = prev_id;
            t_exist++;
        end else if (!m_valid[s] && free_q.size() > 0) begin
            r.is_new    = 1'b1;
            r.id        = free_q.pop_front();
            m_valid[s]  = 1'b1;
            m_key[s]    = key;
            m_id[s]     = r.id;
            m_in_use[r.id] = 1'b1;
            m_slot[r.id]   = s;
            m_fill++;
            t_new++;
        end else begin
            r.valid = 1'b0;
            t_nt++;
        end
        t_req++;
        exp_q.push_back(r);
        prev_valid = r.valid;
        prev_key   = key;
        prev_id    = r.id;
    endtask

    // One clock of stimulus, starting 2 ns after a rising edge
    task automatic drive_cycle(input bit req, input int key);
        i_lookup_req = req;
        i_lookup_key = KEY_W'(key);
        if (req) begin
            model_lookup(key);
        end
        prev_req = req;
        @(posedge clk);
        #2;
        i_lookup_req = 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            prev_req = 1'b0;
            n++;
        end
        if (exp_q.size() > 0) begin
            abort_run("lookup acks");
        end
    endtask

    task automatic wait_init();
        int n;
        n = 0;
        while (o_init_done !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (o_init_done !== 1'b1) begin
            abort_run("o_init_done");
        end
    endtask

    task automatic delete_id(input int id);
        int n;
        prev_req     = 1'b0;
        i_delete_req = 1'b1;
        i_delete_id  = ID_W'(id);
        if (m_in_use[id]) begin
            m_in_use[id]          = 1'b0;
            m_valid[m_slot[id]]   = 1'b0;
            free_q.push_back(id);
            m_fill--;
        end
        @(posedge clk);
        #2;
        i_delete_req = 1'b0;
        n = 0;
        while (o_fill !== (ID_W + 1)'(m_fill) && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (o_fill !== (ID_W + 1)'(m_fill)) begin
            abort_run("o_fill after delete");
        end
    endtask

    // Counters settle one cycle after the last ack
    task automatic check_counters();
        @(posedge clk);
        #2;
        prev_req = 1'b0;
        check_value("o_cnt_req", o_cnt_req, t_req);
        check_value("o_cnt_tracked_existing", o_cnt_tracked_existing, t_exist);
        check_value("o_cnt_tracked_new", o_cnt_tracked_new, t_new);
        check_value("o_cnt_not_tracked", o_cnt_not_tracked, t_nt);
        check_value("o_fill", o_fill, m_fill);
    endtask

    // Results compared mid-cycle
    always @(negedge clk) begin
        result_t r;
        if (o_lookup_ack === 1'b1) begin
            assert (exp_q.size() > 0) else begin
                $display("Error at %0t ns: lookup ack with no lookup in flight", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                r = exp_q.pop_front();
                check_value("o_lookup_ack delay", cycle_cnt - r.cycle, LOOKUP_LATENCY);
                check_value("o_lookup_valid", o_lookup_valid, r.valid);
                check_value("o_lookup_new", o_lookup_new, r.is_new);
                if (r.valid) begin
                    check_value("o_lookup_id", o_lookup_id, r.id);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        int r;
        int key;
        int last_key;
        int rel_cycle;
        htable_srst  = 1'b1;
        i_lookup_req = 1'b0;
        i_lookup_key = '0;
        i_delete_req = 1'b0;
        i_delete_id  = '0;
        i_cnt_clear  = 1'b0;
        last_key     = 1;
        for (int i = 0; i < NUM_IDS; i++) begin
            free_q.push_back(i);
        end
        repeat (4) @(posedge clk);
        #2;
        htable_srst = 1'b0;
        rel_cycle   = cycle_cnt;
        check_value("o_init_done", o_init_done, 0);
        check_value("o_lookup_ack", o_lookup_ack, 0);
        check_value("o_cnt_req", o_cnt_req, 0);
        // Dropped while the free list fills
        i_lookup_req = 1'b1;
        i_lookup_key = 16'h0005;
        @(posedge clk);
        #2;
        i_lookup_req = 1'b0;
        wait_init();
        check_value("o_init_done delay", cycle_cnt - rel_cycle, NUM_IDS);
        end_test("lookup ignored before init");

        for (int i = 1; i <= 4; i++) begin
            drive_cycle(1'b1, i);
        end
        wait_drained();
        end_test("fresh keys take IDs in order");

        drive_cycle(1'b1, 2);
        wait_drained();
        end_test("repeated key hits");

        drive_cycle(1'b1, 16'h0010);
        drive_cycle(1'b1, 16'h0010);
        wait_drained();
        end_test("same key back to back");

        // 0x1000 folds onto the slot of key 1
        drive_cycle(1'b1, 16'h1000);
        for (int k = 20; k <= 46; k++) begin
            drive_cycle(1'b1, k);
        end
        drive_cycle(1'b1, 48);
        wait_drained();
        check_value("o_fill", o_fill, m_fill);
        end_test("collision and full free list");

        delete_id(7);
        delete_id(2);
        drive_cycle(1'b1, 3);
        drive_cycle(1'b1, 22);
        wait_drained();
        drive_cycle(1'b1, 3);
        wait_drained();
        end_test("delete and reissue");

        for (int b = 0; b < 24; b++) begin
            for (int c = 0; c < 8; c++) begin
                r = $random(seed);
                if (((r >> 2) & 3) == 0) begin
                    key = last_key;
                end else if (((r >> 8) & 7) == 0) begin
                    key = 1 + ((r >> 11) & 3);
                end else begin
                    key = (48 + ((r >> 4) & 7)) ^ (((r >> 7) & 1) << 12);
                end
                drive_cycle((r & 3) != 0, key);
                last_key = key;
            end
            wait_drained();
            r = $random(seed);
            if ((r & 1) != 0) begin
                delete_id((r >> 1) & (NUM_IDS - 1));
            end
        end
        check_counters();
        i_cnt_clear = 1'b1;
        @(posedge clk);
        #2;
        i_cnt_clear = 1'b0;
        t_req   = 0;
        t_exist = 0;
        t_new   = 0;
        t_nt    = 0;
        check_value("o_cnt_req", o_cnt_req, 0);
        check_value("o_cnt_tracked_existing", o_cnt_tracked_existing, 0);
        check_value("o_cnt_tracked_new", o_cnt_tracked_new, 0);
        check_value("o_cnt_not_tracked", o_cnt_not_tracked, 0);
        end_test("random run and counter clear");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
design/state_cache_pkg.sv
design/key_table.sv
design/lookup_ctxt_pipe.sv
design/id_allocator.sv
design/lookup_resolver.sv
design/state_cache_top.sv
sim/tb_state_cache_assert.sv
sim/tb_state_cache.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_state_cache \
		-Mdir obj_dir -f flist.f
	-./obj_dir/Vtb_state_cache > sim.log 2>&1
	cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
